/* sim.f */
design/cpu_pkg.sv
design/px.sv
design/pd.sv
design/pa.sv
design/pr.sv
design/cpu.sv
verif/cpu_properties.sv
verif/tb_cpu.sv

/* verif/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	localparam logic [0:15] NOMEM_BASE = 16'hf000; // nothing answers at or above
	localparam int RUN_TIMEOUT = 20000; // clocks per program

	typedef struct packed {
		logic        wr;
		logic [0:15] addr;
		logic [0:15] data;
	} bus_op_t;

	logic        __clk;
	logic        rst_n;
	logic        start;
	logic        rok;
	logic [0:15] rdt;
	logic        dr;
	logic        dw;
	logic [0:15] dad;
	logic [0:15] ddt;
	logic        run;
	logic        hlt_n;
	logic        awaria;

	logic [0:15] mem [0:65535]; // bus memory
	logic [0:15] model_mem [0:1023];
	logic [0:15] m_regs [1:7];
	logic [0:3]  m_flags; // Z M V C
	bit          exp_alarm;
	bus_op_t     exp_q [$]; // bus cycles the model expects
	int          max_lat;
	bit          pending;
	int          lat_left;

	initial begin
		__clk = 1'b0;
		forever #20 __clk = ~__clk;
	end

	cpu cpu_inst (
		.__clk(__clk),
		.rst_n(rst_n),
		.start(start),
		.rok(rok),
		.rdt(rdt),
		.dr(dr),
		.dw(dw),
		.dad(dad),
		.ddt(ddt),
		.run(run),
		.hlt_n(hlt_n),
		.awaria(awaria)
	);

	// ----------------------------------------
	// reporting
	// ----------------------------------------

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	// ----------------------------------------
	// memory responder
	// ----------------------------------------

	always @(posedge __clk) begin : responder
		bus_op_t want;
		if (!rst_n) begin
			rok <= 1'b0;
			pending = 1'b0;
		end else if (rok) begin
			rok <= 1'b0; // one clock per answer
		end else if ((dr || dw) && dad < NOMEM_BASE) begin
			if (!pending) begin
				pending = 1'b1;
				lat_left = $urandom_range(max_lat, 0);
			end
			if (lat_left == 0) begin
				pending = 1'b0;
				rok <= 1'b1;
				if (dw)
					mem[dad] = ddt;
				else
					rdt <= mem[dad];
				if (exp_q.size() == 0) begin
					$display("bus cycle at address %h after the last expected one", dad);
					abort_run();
				end
				want = exp_q.pop_front();
				compare("dw", dw, want.wr);
				compare("dad", dad, want.addr);
				if (dw)
					compare("ddt", ddt, want.data);
			end else begin
				lat_left--;
			end
		end
	end

	// ----------------------------------------
	// instruction-level model
	// ----------------------------------------

	function automatic logic [0:15] fill_word(input int a);
		return 16'(a * 32'h9e37) ^ 16'ha5c3;
	endfunction

	function automatic logic [0:15] reg_value(input logic [0:2] idx);
		if (idx == 3'd0)
			return {m_flags, 12'h000}; // r0 is the flags word
		return m_regs[idx];
	endfunction

	task automatic model_program();
		logic [0:15] pc;
		logic [0:15] w;
		logic [0:15] arg;
		logic [0:15] a;
		logic [0:15] b;
		logic [0:15] res;
		logic [0:3]  op;
		logic [0:3]  fl;
		logic [0:2]  ra;
		bit          done;
		bit          wr;
		int          steps;
		int          sv;
		exp_q.delete();
		exp_alarm = 1'b0;
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done) begin
			w = model_mem[pc];
			exp_q.push_back('{wr: 1'b0, addr: pc, data: 16'h0}); // fetch
			pc++;
			op = w[0:3];
			ra = w[4:6];
			a = reg_value(ra);
			b = reg_value(w[7:9]);
			if (op inside {OP_LW, OP_LD, OP_RW, OP_UJ, OP_JZ}) begin
				arg = model_mem[pc];
				exp_q.push_back('{wr: 1'b0, addr: pc, data: 16'h0});
				pc++;
			end
			wr = 1'b1;
			fl = '0;
			res = '0;
			case (op)
				OP_LW: res = arg;
				OP_LD: begin
					if (arg >= NOMEM_BASE) begin
						exp_alarm = 1'b1; // read never answered
						done = 1'b1;
						wr = 1'b0;
					end else begin
						exp_q.push_back('{wr: 1'b0, addr: arg, data: 16'h0});
						res = model_mem[arg];
					end
				end
				OP_RW: begin
					exp_q.push_back('{wr: 1'b1, addr: arg, data: a});
					model_mem[arg] = a;
					wr = 1'b0;
				end
				OP_AW: begin
					res = a + b;
					sv = int'($signed(a)) + int'($signed(b));
					fl[3] = (int'(a) + int'(b)) > 65535; // carry out
					fl[2] = (sv > 32767) || (sv < -32768);
				end
				OP_SW: begin
					res = a - b;
					sv = int'($signed(a)) - int'($signed(b));
					fl[3] = (a < b); // borrow
					fl[2] = (sv > 32767) || (sv < -32768);
				end
				OP_NR: res = a & b;
				OP_OR: res = a | b;
				OP_ER: res = a ^ b;
				OP_UJ: begin
					pc = arg;
					wr = 1'b0;
				end
				OP_JZ: begin
					if (m_flags[0])
						pc = arg;
					wr = 1'b0;
				end
				default: begin // halt and unused codes
					done = 1'b1;
					wr = 1'b0;
				end
			endcase
			if (wr) begin
				fl[0] = (res == 16'h0000);
				fl[1] = res[0];
				m_flags = fl;
				if (ra != 3'd0)
					m_regs[ra] = res;
			end
			steps++;
			if (steps > 1000) begin
				$display("model did not reach the end of the program");
				abort_run();
			end
		end
	endtask

	// ----------------------------------------
	// program generator
	// ----------------------------------------

	function automatic logic [0:15] instr_word(input logic [0:3] op, input logic [0:2] ra,
			input logic [0:2] rb);
		return {op, ra, rb, 6'h00};
	endfunction

	function automatic logic [0:15] pick_value();
		case ($urandom_range(5, 0))
			0: return 16'h0000;
			1: return 16'h7fff;
			2: return 16'h8000;
			3: return 16'hffff;
			default: return 16'($urandom);
		endcase
	endfunction

	// ending 0 halts, 1 hits an unused code, 2 loads from missing memory
	task automatic build_program(input int ending);
		opcode_e alu_ops [0:4];
		int pc;
		int k;
		int t;
		int starts [$];
		int jmp_arg [$];
		int jmp_idx [$];
		logic [0:2] ra;
		logic [0:2] rb;
		alu_ops = '{OP_AW, OP_SW, OP_NR, OP_OR, OP_ER};
		pc = 0;
		for (int r = 1; r <= 7; r++) begin // fixed start state for r1..r7
			starts.push_back(pc);
			mem[pc] = instr_word(OP_LW, 3'(r), 3'd0);
			mem[pc + 1] = pick_value();
			pc += 2;
		end
		for (int i = $urandom_range(60, 20); i > 0; i--) begin
			ra = 3'($urandom);
			rb = 3'($urandom);
			starts.push_back(pc);
			k = $urandom_range(11, 0);
			if (k < 5) begin
				mem[pc] = instr_word(alu_ops[k], ra, rb);
				pc += 1;
			end else begin
				case (k)
					5: begin
						mem[pc] = instr_word(OP_LW, ra, rb);
						mem[pc + 1] = pick_value();
					end
					6: begin
						mem[pc] = instr_word(OP_LD, ra, rb);
						mem[pc + 1] = 16'(512 + $urandom_range(511, 0));
					end
					7, 8: begin
						if ($urandom_range(2, 0) == 0)
							ra = 3'd0; // store the flags word
						mem[pc] = instr_word(OP_RW, ra, rb);
						mem[pc + 1] = 16'(512 + $urandom_range(511, 0));
					end
					default: begin
						mem[pc] = instr_word((k == 9) ? OP_UJ : OP_JZ, ra, rb);
						jmp_idx.push_back(starts.size() - 1);
						jmp_arg.push_back(pc + 1);
					end
				endcase
				pc += 2;
			end
		end
		starts.push_back(pc);
		case (ending)
			1: mem[pc] = instr_word(4'($urandom_range(15, 11)), 3'd0, 3'd0);
			2: begin
				mem[pc] = instr_word(OP_LD, 3'($urandom), 3'd0);
				mem[pc + 1] = NOMEM_BASE | 16'($urandom_range(4095, 0));
			end
			default: mem[pc] = instr_word(OP_HLT, 3'd0, 3'd0);
		endcase
		// jump targets go forward to an instruction start
		for (int j = 0; j < jmp_idx.size(); j++) begin
			t = $urandom_range(starts.size() - 1, jmp_idx[j] + 1);
			mem[jmp_arg[j]] = 16'(starts[t]);
		end
	endtask

	// ----------------------------------------
	// one run from start to stop
	// ----------------------------------------

	task automatic run_program();
		int cycles;
		int aw_len;
		for (int a = 512; a < 1024; a++)
			mem[a] = fill_word(a);
		for (int a = 0; a < 1024; a++)
			model_mem[a] = mem[a];
		model_program();
		@(posedge __clk);
		start <= 1'b1;
		@(posedge __clk);
		start <= 1'b0;
		cycles = 0;
		while (!run) begin
			@(negedge __clk);
			cycles++;
			if (cycles > 4) begin
				$display("core did not start running after the start pulse");
				abort_run();
			end
		end
		compare("hlt_n", hlt_n, 1'b1);
		cycles = 0;
		aw_len = 0;
		while (run) begin
			@(negedge __clk);
			if (awaria)
				aw_len++;
			cycles++;
			if (cycles > RUN_TIMEOUT) begin
				$display("core still running after %0d clocks", RUN_TIMEOUT);
				abort_run();
			end
		end
		compare("hlt_n", hlt_n, 1'b0);
		compare("awaria", awaria, 1'b0);
		compare("awaria width", aw_len, exp_alarm ? ALARM_TICKS : 0);
		compare("missing bus cycles", exp_q.size(), 0);
		repeat (8) begin // stopped core stays off the bus
			@(negedge __clk);
			compare("dr", dr, 1'b0);
			compare("dw", dw, 1'b0);
			compare("run", run, 1'b0);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		void'($urandom(32'hc78b_63b9));
		rst_n = 1'b0;
		start = 1'b0;
		rok = 1'b0;
		rdt = '0;
		max_lat = 7;
		for (int a = 0; a < 65536; a++)
			mem[a] = fill_word(a);
		for (int r = 1; r <= 7; r++)
			m_regs[r] = '0;
		m_flags = '0;
		repeat (3) @(posedge __clk);
		rst_n <= 1'b1;
		@(negedge __clk);
		compare("run", run, 1'b0);
		compare("dr", dr, 1'b0);
		compare("dw", dw, 1'b0);
		compare("awaria", awaria, 1'b0);
		compare("hlt_n", hlt_n, 1'b1);

		// each program twice, slow memory then zero latency
		for (int p = 0; p < 3; p++) begin
			build_program(0);
			max_lat = 7;
			run_program();
			max_lat = 0;
			run_program();
		end

		max_lat = 5;
		build_program(1); // unused opcode
		run_program();
		build_program(2); // alarm
		run_program();
		build_program(0); // restart after the alarm
		run_program();

		if (cpu_inst.PX.props_inst.fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties import cpu_pkg::*; (
	input logic      __clk,
	input logic      rst_n,
	input logic      rok,
	input logic      dr,
	input logic      dw,
	input logic      awaria,
	input px_state_e state
);

	int fail_cnt = 0; // failed assertions so far

	// ----------------------------------------
	// bus strobes
	// ----------------------------------------

	a_one_strobe: assert property (@(posedge __clk) disable iff (!rst_n)
		!(dr && dw))
		else begin
			$error("dr and dw high together");
			fail_cnt++;
		end

	// a strobe waits for rok, only the alarm may cut it short
	a_dr_hold: assert property (@(posedge __clk) disable iff (!rst_n)
		(dr && !rok) |=> (dr || awaria))
		else begin
			$error("dr dropped before rok");
			fail_cnt++;
		end

	a_dw_hold: assert property (@(posedge __clk) disable iff (!rst_n)
		(dw && !rok) |=> (dw || awaria))
		else begin
			$error("dw dropped before rok");
			fail_cnt++;
		end

	// ----------------------------------------
	// phase lengths
	// ----------------------------------------

	a_strob1_len: assert property (@(posedge __clk) disable iff (!rst_n)
		$rose(state == ST_STROB1) |->
			(state == ST_STROB1)[*STROB1_TICKS] ##1 (state != ST_STROB1))
		else begin
			$error("STROB1 phase has the wrong length");
			fail_cnt++;
		end

	a_awaria_len: assert property (@(posedge __clk) disable iff (!rst_n)
		$rose(awaria) |-> awaria[*ALARM_TICKS] ##1 !awaria)
		else begin
			$error("awaria pulse has the wrong width");
			fail_cnt++;
		end

endmodule

bind px cpu_properties props_inst (
	.__clk(__clk),
	.rst_n(rst_n),
	.rok(rok),
	.dr(dr),
	.dw(dw),
	.awaria(awaria),
	.state(state)
);

`default_nettype wire

/* design/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
	input  logic        __clk,
	input  logic        rst_n,
	input  logic        start,

	// system bus
	input  logic        rok,
	input  logic [0:15] rdt,
	output logic        dr,
	output logic        dw,
	output logic [0:15] dad,
	output logic [0:15] ddt,

	// status
	output logic        run,
	output logic        hlt_n,
	output logic        awaria
);

	// ----------------------------------------
	// px timing sequencer
	// ----------------------------------------

	dec_t dec;
	logic w_ir, w_arg, strob2, icp1, jmp, ar_ad;

	px PX(
		.__clk(__clk),
		.rst_n(rst_n),
		.start(start),
		.rok(rok),
		.dec(dec),
		.dr(dr),
		.dw(dw),
		.w_ir(w_ir),
		.w_arg(w_arg),
		.strob2(strob2),
		.icp1(icp1),
		.jmp(jmp),
		.ar_ad(ar_ad),
		.run(run),
		.hlt_n(hlt_n),
		.awaria(awaria)
	);

	// ----------------------------------------
	// pd decoder
	// ----------------------------------------

	pd PD(
		.__clk(__clk),
		.rst_n(rst_n),
		.w_ir(w_ir),
		.rdt(rdt),
		.dec(dec)
	);

	// ----------------------------------------
	// pa arithmetic, pr registers
	// ----------------------------------------

	reg_wr_t reg_wr;
	logic [0:15] ra_data, rb_data;
	logic [0:3] flags;

	pa PA(
		.__clk(__clk),
		.rst_n(rst_n),
		.dec(dec),
		.rdt(rdt),
		.w_arg(w_arg),
		.strob2(strob2),
		.icp1(icp1),
		.jmp(jmp),
		.ar_ad(ar_ad),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.flags(flags),
		.dad(dad),
		.ddt(ddt),
		.reg_wr(reg_wr)
	);

	pr PR(
		.__clk(__clk),
		.rst_n(rst_n),
		.reg_wr(reg_wr),
		.ra_idx(dec.ra),
		.rb_idx(dec.rb),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.flags(flags)
	);

endmodule

`default_nettype wire

/* design/pr.sv */
`timescale 1ns/1ps
`default_nettype none

module pr import cpu_pkg::*; (
	input  logic        __clk,
	input  logic        rst_n,
	input  reg_wr_t     reg_wr,
	input  logic [0:2]  ra_idx,
	input  logic [0:2]  rb_idx,
	output logic [0:15] ra_data,
	output logic [0:15] rb_data,
	output logic [0:3]  flags
);

	logic [0:15] regs [1:7]; // r1..r7
	logic [0:3]  r0; // flags Z M V C

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			r0 <= '0;
			for (int i = 1; i <= 7; i++)
				regs[i] <= '0;
		end else if (reg_wr.en) begin
			r0 <= reg_wr.flags; // also on writes to r0
			if (reg_wr.idx != 3'd0)
				regs[reg_wr.idx] <= reg_wr.data;
		end
	end

	// r0 reads back as flags in the top bits
	assign ra_data = (ra_idx == 3'd0) ? {r0, 12'h000} : regs[ra_idx];
	assign rb_data = (rb_idx == 3'd0) ? {r0, 12'h000} : regs[rb_idx];

	assign flags = r0;

endmodule

`default_nettype wire

/* design/pa.sv */
`timescale 1ns/1ps
`default_nettype none

module pa import cpu_pkg::*; (
	input  logic        __clk,
	input  logic        rst_n,
	input  dec_t        dec,
	input  logic [0:15] rdt,
	input  logic        w_arg,
	input  logic        strob2,
	input  logic        icp1,
	input  logic        jmp,
	input  logic        ar_ad,
	input  logic [0:15] ra_data,
	input  logic [0:15] rb_data,
	input  logic [0:3]  flags,
	output logic [0:15] dad,
	output logic [0:15] ddt,
	output reg_wr_t     reg_wr
);

	logic [0:15] ic;
	logic [0:15] ar;
	logic [0:15] dt; // data word from a memory read
	logic [0:16] sum_x;
	logic [0:16] dif_x;
	logic [0:15] res;
	logic [0:3]  res_flags;
	logic        take_jmp;

	// ----------------------------------------
	// ic, ar and read data
	// ----------------------------------------

	assign take_jmp = (dec.op == OP_UJ) || flags[FLAG_Z]; // JZ only on stored Z

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			ic <= '0;
			ar <= '0;
		end else begin
			if (jmp && !strob2)
				ic <= '0; // restart from stop
			else if (jmp && take_jmp)
				ic <= ar;
			else if (icp1)
				ic <= ic + 16'd1;
			if (w_arg && !ar_ad)
				ar <= rdt; // argument word
		end
	end

	always_ff @(posedge __clk) begin
		if (w_arg && ar_ad)
			dt <= rdt;
	end

	assign dad = ar_ad ? ar : ic;
	assign ddt = ra_data;

	// ----------------------------------------
	// ALU
	// ----------------------------------------

	always_comb begin
		sum_x = {1'b0, ra_data} + {1'b0, rb_data};
		dif_x = {1'b0, ra_data} - {1'b0, rb_data}; // msb is the borrow
		res = '0;
		res_flags = '0;
		case (dec.op)
			OP_AW: begin
				res = sum_x[1:16];
				res_flags[FLAG_C] = sum_x[0];
				res_flags[FLAG_V] = (ra_data[0] == rb_data[0]) && (res[0] != ra_data[0]);
			end
			OP_SW: begin
				res = dif_x[1:16];
				res_flags[FLAG_C] = dif_x[0];
				res_flags[FLAG_V] = (ra_data[0] != rb_data[0]) && (res[0] != ra_data[0]);
			end
			OP_NR: res = ra_data & rb_data;
			OP_OR: res = ra_data | rb_data;
			OP_ER: res = ra_data ^ rb_data;
			OP_LW: res = ar; // immediate
			OP_LD: res = dt;
			default: res = '0;
		endcase
		res_flags[FLAG_Z] = (res == 16'h0000);
		res_flags[FLAG_M] = res[0];
	end

	assign reg_wr = '{
		en: strob2 && dec.reg_wr,
		idx: dec.ra,
		data: res,
		flags: res_flags
	};

endmodule

`default_nettype wire

/* design/pd.sv */
`timescale 1ns/1ps
`default_nettype none

module pd import cpu_pkg::*; (
	input  logic        __clk,
	input  logic        rst_n,
	input  logic        w_ir,
	input  logic [0:15] rdt,
	output dec_t        dec
);

	logic [0:15] ir;
	opcode_e op_raw;

	always_ff @(posedge __clk) begin
		if (!rst_n)
			ir <= '0;
		else if (w_ir)
			ir <= rdt; // fetched instruction word
	end

	assign op_raw = opcode_e'(ir[0:3]);

	// ----------------------------------------
	// decoder
	// ----------------------------------------

	always_comb begin
		dec = '0;
		dec.op = op_raw;
		dec.ra = ir[4:6];
		dec.rb = ir[7:9];
		case (op_raw)
			OP_LW: begin
				dec.two_word = 1'b1;
				dec.reg_wr = 1'b1;
			end
			OP_LD: begin
				dec.two_word = 1'b1;
				dec.mem_rd = 1'b1;
				dec.reg_wr = 1'b1;
			end
			OP_RW: begin
				dec.two_word = 1'b1;
				dec.mem_wr = 1'b1;
			end
			OP_AW, OP_SW, OP_NR, OP_OR, OP_ER:
				dec.reg_wr = 1'b1; // ra <= ra op rb
			OP_UJ, OP_JZ:
				dec.two_word = 1'b1; // target in second word
			OP_HLT: ;
			default: begin
				dec.op = OP_HLT; // unknown code stops the core
				dec.illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/px.sv */
`timescale 1ns/1ps
`default_nettype none

module px import cpu_pkg::*; (
	input  logic __clk,
	input  logic rst_n,
	input  logic start,
	input  logic rok,
	input  dec_t dec,
	output logic dr,
	output logic dw,
	output logic w_ir,
	output logic w_arg,
	output logic strob2,
	output logic icp1,
	output logic jmp,
	output logic ar_ad,
	output logic run,
	output logic hlt_n,
	output logic awaria
);

	px_state_e state, state_nx;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] lim;
	logic cnt_done;
	logic stop_op;
	logic bus_cyc;

	assign stop_op = dec.illegal || (dec.op == OP_HLT);
	assign bus_cyc = (state == ST_FETCH) || (state == ST_ARG) ||
		(state == ST_MEM) || (state == ST_WRITE);

	// ----------------------------------------
	// shared tick counter
	// ----------------------------------------

	always_comb begin
		case (state)
			ST_STROB1: lim = CNT_W'(STROB1_TICKS - 1);
			ST_STROB2: lim = CNT_W'(STROB2_TICKS - 1);
			ST_ALARM:  lim = CNT_W'(ALARM_TICKS - 1);
			default:   lim = CNT_W'(ALARM_DLY_TICKS - 1); // any bus cycle
		endcase
	end

	assign cnt_done = (cnt == lim);

	// ----------------------------------------
	// phase sequence
	// ----------------------------------------

	always_comb begin
		state_nx = state;
		case (state)
			ST_STOP:
				if (start) state_nx = ST_FETCH;
			ST_STROB1:
				if (cnt_done) state_nx = dec.two_word ? ST_ARG : ST_STROB2;
			ST_STROB2:
				if (cnt_done) state_nx = stop_op ? ST_STOP : ST_FETCH;
			ST_ALARM:
				if (cnt_done) state_nx = ST_STOP;
			default: begin // bus cycles wait for rok
				if (rok) begin
					if (state == ST_FETCH) state_nx = ST_STROB1;
					else if (state != ST_ARG) state_nx = ST_STROB2;
					else if (dec.mem_rd) state_nx = ST_MEM;
					else if (dec.mem_wr) state_nx = ST_WRITE;
					else state_nx = ST_STROB2;
				end else if (cnt_done) begin
					state_nx = ST_ALARM; // nobody answered
				end
			end
		endcase
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= ST_STOP;
			cnt <= '0;
			hlt_n <= 1'b1;
		end else begin
			state <= state_nx;
			cnt <= (state_nx != state) ? '0 : cnt + 1'b1; // restart on every phase
			if (state == ST_STOP && start)
				hlt_n <= 1'b1;
			else if (state != ST_STOP && state_nx == ST_STOP)
				hlt_n <= 1'b0;
		end
	end

	// ----------------------------------------
	// strobes and pulses
	// ----------------------------------------

	assign dr = bus_cyc && (state != ST_WRITE);
	assign dw = (state == ST_WRITE);
	assign ar_ad = (state == ST_MEM) || (state == ST_WRITE); // data address from ar

	assign w_ir = (state == ST_FETCH) && rok;
	assign w_arg = ((state == ST_ARG) || (state == ST_MEM)) && rok;
	assign icp1 = ((state == ST_FETCH) || (state == ST_ARG)) && rok; // once per word

	assign strob2 = (state == ST_STROB2) && cnt_done;
	// a bare jmp while stopped sends ic back to 0
	assign jmp = (strob2 && (dec.op == OP_UJ || dec.op == OP_JZ)) ||
		(state == ST_STOP && start);

	assign run = (state != ST_STOP);
	assign awaria = (state == ST_ALARM);

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// ----------------------------------------
	// core timings, in clock ticks
	// ----------------------------------------

	localparam int CNT_W = 8; // wide enough for the alarm delay

	localparam int STROB1_TICKS = 5;
	localparam int STROB2_TICKS = 6;

	localparam int ALARM_DLY_TICKS = 250; // ticks without rok before the alarm
	localparam int ALARM_TICKS = 3; // awaria pulse width

	// flag positions in r0, bit 0 first
	localparam int FLAG_Z = 0;
	localparam int FLAG_M = 1;
	localparam int FLAG_V = 2;
	localparam int FLAG_C = 3;

	// ----------------------------------------
	// instruction set
	// ----------------------------------------

	typedef enum logic [0:3] {
		OP_LW  = 4'h0, // ra <= immediate
		OP_LD  = 4'h1, // ra <= mem[arg]
		OP_RW  = 4'h2, // mem[arg] <= ra
		OP_AW  = 4'h3,
		OP_SW  = 4'h4,
		OP_NR  = 4'h5,
		OP_OR  = 4'h6,
		OP_ER  = 4'h7,
		OP_UJ  = 4'h8,
		OP_JZ  = 4'h9,
		OP_HLT = 4'ha
	} opcode_e;

	typedef enum logic [2:0] {
		ST_STOP,
		ST_FETCH,
		ST_STROB1,
		ST_ARG,
		ST_STROB2,
		ST_MEM,
		ST_WRITE,
		ST_ALARM
	} px_state_e;

	// decoded instruction, pd -> px, pa
	typedef struct packed {
		opcode_e    op;
		logic [0:2] ra;
		logic [0:2] rb;
		logic       two_word; // argument word follows
		logic       mem_rd;
		logic       mem_wr;
		logic       reg_wr;
		logic       illegal;
	} dec_t;

	// register file write, pa -> pr
	typedef struct packed {
		logic        en;
		logic [0:2]  idx;
		logic [0:15] data;
		logic [0:3]  flags; // Z M V C
	} reg_wr_t;

endpackage

`default_nettype wire
